/* source/butterfly_pkg.sv */
// q16.16 signed samples only; products truncate toward minus infinity and sums wrap modulo 2^32
`default_nettype none

package butterfly_pkg;

  // ========================================
  // fixed-point format
  // ========================================

  // total sample width in bits
  localparam int data_width = 32;
  // fraction bits, so one lsb is 2^-16
  localparam int frac_bits = 16;

  // ========================================
  // datapath types
  // ========================================

  // one complex sample, real part in the upper half
  typedef struct packed {
    logic signed [data_width-1:0] re;
    logic signed [data_width-1:0] im;
  } complex_t;

  // operand set of a single butterfly
  // c = a + w*b, d = a - w*b
  typedef struct packed {
    complex_t a;
    complex_t b;
    complex_t w;
  } butterfly_in_t;

  // result pair of a single butterfly
  typedef struct packed {
    complex_t c;
    complex_t d;
  } butterfly_out_t;

  // ========================================
  // sequencer states
  // ========================================

  // IDLE waits for a batch, COMP walks the lanes,
  // DONE holds results until the consumer takes them
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    COMP = 2'd1,
    DONE = 2'd2
  } bfly_state_e;

endpackage

`default_nettype wire

/* source/bfly_control_fsm.sv */
// one batch in flight at a time; relies on last being asserted in the final compute cycle
`default_nettype none
`timescale 1ns/100ps

module bfly_control_fsm (
  input  logic clk,
  input  logic reset,
  input  logic recv_val,
  input  logic send_rdy,
  input  logic last,
  output logic recv_rdy,
  output logic send_val,
  output logic load,
  output logic compute
);

  import butterfly_pkg::*;

  bfly_state_e state_q;
  bfly_state_e state_d;

  // ========================================
  // state register
  // ========================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ========================================
  // next state
  // ========================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // batch accepted, lane walk starts next edge
        if (recv_val) begin
          state_d = COMP;
        end
      end
      COMP: begin
        // final lane written on this edge
        if (last) begin
          state_d = DONE;
        end
      end
      DONE: begin
        // consumer took the results
        if (send_rdy) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ========================================
  // handshake and datapath steering
  // ========================================

  // only ready for a new batch when nothing is held
  assign recv_rdy = (state_q == IDLE);
  assign send_val = (state_q == DONE);

  // load equals acceptance, single cycle by construction
  assign load = recv_val && (state_q == IDLE);

  // lane counter enable and result write enable
  assign compute = (state_q == COMP);

endmodule

`default_nettype wire

/* source/lane_counter.sv */
// counts 0..lanes-1 while enabled and sits at 0 otherwise; lanes must be at least 1
`default_nettype none
`timescale 1ns/100ps

module lane_counter #(
  parameter int lanes = 4,
  localparam int lane_w = (lanes > 1) ? $clog2(lanes) : 1
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable,
  output logic [lane_w-1:0] lane,
  output logic              last
);

  // index of the final lane, sized to the counter
  localparam logic [lane_w-1:0] last_lane = lane_w'(lanes - 1);

  // modulo-lanes count, cleared whenever the compute phase is off
  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      lane <= '0;
    end else if (last) begin
      // wrap after the final lane
      lane <= '0;
    end else begin
      lane <= lane + 1'b1;
    end
  end

  // decoded here so the sequencer stays independent of lanes
  assign last = (lane == last_lane);

endmodule

`default_nettype wire

/* source/complex_multiplier.sv */
// zero latency q16.16 complex product; result is floor(x*y / 2^16) truncated to 32 bits per part
`default_nettype none
`timescale 1ns/100ps

module complex_multiplier (
  input  butterfly_pkg::complex_t x,
  input  butterfly_pkg::complex_t y,
  output butterfly_pkg::complex_t product
);

  import butterfly_pkg::*;

  // one guard bit so operand sums cannot overflow
  localparam int ext_w = data_width + 1;
  // full product width with headroom for the final add or subtract
  localparam int prod_w = 2 * ext_w;

  // ========================================
  // operand extension and pre-adds
  // ========================================

  logic signed [ext_w-1:0] xr;
  logic signed [ext_w-1:0] xi;
  logic signed [ext_w-1:0] yr;
  logic signed [ext_w-1:0] yi;
  logic signed [ext_w-1:0] x_sum;
  logic signed [ext_w-1:0] y_diff;
  logic signed [ext_w-1:0] y_sum;

  assign xr = ext_w'(x.re);
  assign xi = ext_w'(x.im);
  assign yr = ext_w'(y.re);
  assign yi = ext_w'(y.im);

  assign x_sum  = xr + xi;
  assign y_diff = yi - yr;
  assign y_sum  = yr + yi;

  // ========================================
  // three multiplications
  // ========================================

  logic signed [prod_w-1:0] k_shared;
  logic signed [prod_w-1:0] k_im;
  logic signed [prod_w-1:0] k_re;
  logic signed [prod_w-1:0] re_full;
  logic signed [prod_w-1:0] im_full;

  // shared cross term yr*(xr + xi)
  assign k_shared = yr * x_sum;
  // imaginary correction xr*(yi - yr)
  assign k_im = xr * y_diff;
  // real correction xi*(yr + yi)
  assign k_re = xi * y_sum;

  // re = xr*yr - xi*yi, im = xr*yi + xi*yr, both exact
  assign re_full = k_shared - k_re;
  assign im_full = k_shared + k_im;

  // arithmetic shift by frac_bits then keep data_width bits
  assign product.re = re_full[frac_bits +: data_width];
  assign product.im = im_full[frac_bits +: data_width];

endmodule

`default_nettype wire

/* source/butterfly_lane_bank.sv */
// operands are captured only on load; lane must stay below lanes while compute is high
`default_nettype none
`timescale 1ns/100ps

module butterfly_lane_bank #(
  parameter int lanes = 4,
  localparam int lane_w = (lanes > 1) ? $clog2(lanes) : 1
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           load,
  input  logic                           compute,
  input  logic [lane_w-1:0]              lane,
  input  butterfly_pkg::butterfly_in_t   batch_in  [lanes],
  output butterfly_pkg::butterfly_out_t  batch_out [lanes]
);

  import butterfly_pkg::*;

  // ========================================
  // storage
  // ========================================

  // captured operand sets, one per lane
  butterfly_in_t  ops_q [lanes];
  // result pairs, one per lane
  butterfly_out_t res_q [lanes];

  // operands only change on acceptance
  always_ff @(posedge clk) begin
    if (load) begin
      ops_q <= batch_in;
    end
  end

  // ========================================
  // selected lane datapath
  // ========================================

  butterfly_in_t  sel_ops;
  complex_t       wb;
  butterfly_out_t lane_res;

  // lane mux feeding the single multiplier
  assign sel_ops = ops_q[lane];

  complex_multiplier i_cmul (
    .x       (sel_ops.w),
    .y       (sel_ops.b),
    .product (wb)
  );

  // add/subtract around the product, wrapping modulo 2^data_width
  always_comb begin
    lane_res.c.re = sel_ops.a.re + wb.re;
    lane_res.c.im = sel_ops.a.im + wb.im;
    lane_res.d.re = sel_ops.a.re - wb.re;
    lane_res.d.im = sel_ops.a.im - wb.im;
  end

  // ========================================
  // result registers
  // ========================================

  // cleared on reset and on every new batch,
  // written one cycle after the lane is selected
  always_ff @(posedge clk) begin
    for (int i = 0; i < lanes; i++) begin
      if (reset || load) begin
        res_q[i] <= '0;
      end else if (compute && (lane == lane_w'(i))) begin
        res_q[i] <= lane_res;
      end
    end
  end

  // results go straight to the output port
  assign batch_out = res_q;

endmodule

`default_nettype wire

/* source/multi_butterfly.sv */
// one batch of lanes butterflies per handshake; result appears lanes cycles after acceptance
`default_nettype none
`timescale 1ns/100ps

module multi_butterfly #(
  parameter int lanes = 4,
  localparam int lane_w = (lanes > 1) ? $clog2(lanes) : 1
) (
  input  logic                          clk,
  input  logic                          reset,

  // producer side
  input  logic                          recv_val,
  output logic                          recv_rdy,
  input  butterfly_pkg::butterfly_in_t  batch_in  [lanes],

  // consumer side
  output logic                          send_val,
  input  logic                          send_rdy,
  output butterfly_pkg::butterfly_out_t batch_out [lanes]
);

  // ========================================
  // internal control nets
  // ========================================

  // acceptance pulse, captures operands and clears results
  logic              load;
  // high for the whole lane walk
  logic              compute;
  // lane being computed this cycle
  logic [lane_w-1:0] lane;
  // final lane flag back to the sequencer
  logic              last;

  // ========================================
  // sequencer
  // ========================================

  bfly_control_fsm i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .send_rdy (send_rdy),
    .last     (last),
    .recv_rdy (recv_rdy),
    .send_val (send_val),
    .load     (load),
    .compute  (compute)
  );

  // ========================================
  // lane index
  // ========================================

  lane_counter #(
    .lanes (lanes)
  ) i_lane_cnt (
    .clk    (clk),
    .reset  (reset),
    .enable (compute),
    .lane   (lane),
    .last   (last)
  );

  // ========================================
  // datapath
  // ========================================

  butterfly_lane_bank #(
    .lanes (lanes)
  ) i_bank (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .compute   (compute),
    .lane      (lane),
    .batch_in  (batch_in),
    .batch_out (batch_out)
  );

endmodule

`default_nettype wire

/* dv/multi_butterfly_assert.sv */
// handshake checks for multi_butterfly; assumes send_val rises on the edge that writes the last lane
`default_nettype none
`timescale 1ns/100ps

module multi_butterfly_assert #(
  parameter int lanes = 4
) (
  input logic                          clk,
  input logic                          reset,
  input logic                          recv_val,
  input logic                          recv_rdy,
  input logic                          send_val,
  input logic                          send_rdy,
  input butterfly_pkg::butterfly_out_t batch_out [lanes]
);

  import butterfly_pkg::*;

  localparam int out_w = $bits(butterfly_out_t);
  // the high level is sampled one edge after the acceptance edge and the lanes write edges
  localparam int rise_delay = lanes + 1;

  // all lanes in one vector for the stability check
  logic [lanes*out_w-1:0] out_flat;

  always_comb begin
    for (int i = 0; i < lanes; i++) begin
      out_flat[i*out_w +: out_w] = batch_out[i];
    end
  end

  // ========================================
  // properties
  // ========================================

  // never ready for input while holding results
  assert property (@(posedge clk) disable iff (reset) !(recv_rdy && send_val))
    else $error("recv_rdy and send_val high in the same cycle");

  // held results stay put under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    (send_val && !send_rdy) |=> (send_val && $stable(out_flat)))
    else $error("send_val or batch_out changed while send_rdy was low");

  // send_val rises if and only if a batch was accepted lanes cycles before
  assert property (@(posedge clk) disable iff (reset)
    $rose(send_val) == $past(recv_val && recv_rdy, rise_delay))
    else $error("send_val rise not aligned to the accepting edge");

endmodule

bind multi_butterfly multi_butterfly_assert #(
  .lanes (lanes)
) i_assert (
  .clk       (clk),
  .reset     (reset),
  .recv_val  (recv_val),
  .recv_rdy  (recv_rdy),
  .send_val  (send_val),
  .send_rdy  (send_rdy),
  .batch_out (batch_out)
);

`default_nettype wire

/* dv/multi_butterfly_tb.sv */
// lanes fixed at 4; stimulus comes from a fixed-seed LCG, so every run repeats the same 200 batches
`default_nettype none
`timescale 1ns/100ps

module multi_butterfly_tb;

  import butterfly_pkg::*;

  localparam int lanes = 4;
  localparam int batches = 200;
  // worst case per batch is gap, accept, lane walk, stall and consume
  localparam int max_cycles = batches * (lanes + 2 + 3 + 7) + 50;

  logic           clk;
  logic           reset;
  logic           recv_val;
  logic           recv_rdy;
  logic           send_val;
  logic           send_rdy;
  butterfly_in_t  batch_in  [lanes];
  butterfly_out_t batch_out [lanes];

  // model results for the batch in flight
  butterfly_out_t expected [lanes];
  logic [31:0]    lcg_state;
  int             cycle_count;

  multi_butterfly #(
    .lanes (lanes)
  ) i_dut (
    .clk       (clk),
    .reset     (reset),
    .recv_val  (recv_val),
    .recv_rdy  (recv_rdy),
    .batch_in  (batch_in),
    .send_val  (send_val),
    .send_rdy  (send_rdy),
    .batch_out (batch_out)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // cycle limit ends a stuck handshake
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the unit gave no result within %0d clock cycles", max_cycles);
      $display("Some tests failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // ========================================
  // random numbers
  // ========================================

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // draws from the upper bits since the low LCG bits have short periods
  function automatic int random_below(int n);
    return int'((next_random() >> 8) % n);
  endfunction

  // extreme words are full scale positive, full scale negative or zero
  function automatic logic [31:0] random_word(bit extreme);
    logic [31:0] hi;
    logic [31:0] lo;
    if (extreme) begin
      case (random_below(3))
        0: return 32'h7fff_ffff;
        1: return 32'h8000_0000;
        default: return 32'h0000_0000;
      endcase
    end
    hi = next_random();
    lo = next_random();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic complex_t random_complex(bit extreme);
    complex_t r;
    r.re = random_word(extreme);
    r.im = random_word(extreme);
    return r;
  endfunction

  // ========================================
  // reference model
  // ========================================

  // four-multiplication form at full precision followed by floor shift and truncation
  function automatic complex_t model_product(complex_t x, complex_t y);
    logic signed [65:0] re_full;
    logic signed [65:0] im_full;
    complex_t           r;
    re_full = 66'(x.re) * 66'(y.re) - 66'(x.im) * 66'(y.im);
    im_full = 66'(x.re) * 66'(y.im) + 66'(x.im) * 66'(y.re);
    r.re = 32'(re_full >>> frac_bits);
    r.im = 32'(im_full >>> frac_bits);
    return r;
  endfunction

  // sums wrap modulo 2^32 by the 32-bit result fields
  function automatic butterfly_out_t model_butterfly(butterfly_in_t op);
    complex_t       p;
    butterfly_out_t r;
    p = model_product(op.w, op.b);
    r.c.re = op.a.re + p.re;
    r.c.im = op.a.im + p.im;
    r.d.re = op.a.re - p.re;
    r.d.im = op.a.im - p.im;
    return r;
  endfunction

  // ========================================
  // compare tasks
  // ========================================

  task automatic compare_complex(string name, complex_t exp_val, complex_t act_val);
    if (act_val !== exp_val) begin
      $display("FAILED %s: expected re=%h im=%h, actual re=%h im=%h",
               name, exp_val.re, exp_val.im, act_val.re, act_val.im);
      $display("Some tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic compare_level(string name, logic exp_val, logic act_val);
    if (act_val !== exp_val) begin
      $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
      $display("Some tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // lanes below written hold the model results, the others still read as cleared
  task automatic check_lanes(int written);
    complex_t zero;
    zero = '0;
    for (int i = 0; i < lanes; i++) begin
      if (i < written) begin
        compare_complex($sformatf("batch_out[%0d].c", i), expected[i].c, batch_out[i].c);
        compare_complex($sformatf("batch_out[%0d].d", i), expected[i].d, batch_out[i].d);
      end else begin
        compare_complex($sformatf("batch_out[%0d].c", i), zero, batch_out[i].c);
        compare_complex($sformatf("batch_out[%0d].d", i), zero, batch_out[i].d);
      end
    end
  endtask

  // ========================================
  // stimulus
  // ========================================

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // junk operands and stray recv_val while the unit is busy
  task automatic drive_noise();
    recv_val = (random_below(2) == 1);
    for (int i = 0; i < lanes; i++) begin
      batch_in[i].a = random_complex(1'b0);
      batch_in[i].b = random_complex(1'b0);
      batch_in[i].w = random_complex(1'b0);
    end
  endtask

  task automatic run_batch(bit extreme);
    int gap;
    int stall;
    gap = random_below(4);
    stall = random_below(8);
    recv_val = 1'b0;
    send_rdy = 1'b0;
    repeat (gap) next_cycle();
    // new batch and its expected results
    for (int i = 0; i < lanes; i++) begin
      batch_in[i].a = random_complex(extreme);
      batch_in[i].b = random_complex(extreme);
      batch_in[i].w = random_complex(extreme);
      expected[i] = model_butterfly(batch_in[i]);
    end
    compare_level("recv_rdy", 1'b1, recv_rdy);
    recv_val = 1'b1;
    next_cycle();
    // one lane written per cycle of the lane walk
    // send_val must show up on the lanes-th cycle and not before
    for (int j = 1; j <= lanes; j++) begin
      drive_noise();
      send_rdy = (random_below(2) == 1);
      next_cycle();
      compare_level("recv_rdy", 1'b0, recv_rdy);
      compare_level("send_val", (j == lanes), send_val);
      check_lanes(j);
    end
    send_rdy = 1'b0;
    // results have to hold under back-pressure
    repeat (stall) begin
      drive_noise();
      next_cycle();
      compare_level("send_val", 1'b1, send_val);
      compare_level("recv_rdy", 1'b0, recv_rdy);
      check_lanes(lanes);
    end
    send_rdy = 1'b1;
    next_cycle();
    send_rdy = 1'b0;
    recv_val = 1'b0;
    compare_level("recv_rdy", 1'b1, recv_rdy);
    compare_level("send_val", 1'b0, send_val);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    recv_val = 1'b0;
    send_rdy = 1'b0;
    lcg_state = 32'hd5a1;
    cycle_count = 0;
    for (int i = 0; i < lanes; i++) begin
      batch_in[i] = '0;
      expected[i] = '0;
    end
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    // idle levels and cleared results straight after reset
    compare_level("recv_rdy", 1'b1, recv_rdy);
    compare_level("send_val", 1'b0, send_val);
    check_lanes(0);
    // every eighth batch at full scale
    for (int b = 0; b < batches; b++) begin
      run_batch((b % 8) == 7);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
source/butterfly_pkg.sv
source/bfly_control_fsm.sv
source/lane_counter.sv
source/complex_multiplier.sv
source/butterfly_lane_bank.sv
source/multi_butterfly.sv
dv/multi_butterfly_assert.sv
dv/multi_butterfly_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := multi_butterfly_tb
FILE_LIST := verilog.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed
SOURCES   := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "result: failure reported in $(LOG)"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "result: pass"; \
	else \
	  echo "result: run ended without a completion line"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
